/* source/issue_pkg.sv */
package issue_pkg;

    // machine size
    localparam int NUM_FU   = 5;   // int, mul1, mul2, branch, ld/st
    localparam int FU_IDX_W = 3;   // enough to index NUM_FU units
    localparam int TAG_W    = 4;
    localparam int LAT_W    = 4;   // latency and countdown width

    // functional unit index, also the bit position in per-unit vectors
    typedef enum logic [FU_IDX_W-1:0] {
        FU_INT    = 3'd0,
        FU_MUL1   = 3'd1,
        FU_MUL2   = 3'd2,
        FU_BRANCH = 3'd3,
        FU_LDST   = 3'd4
    } fu_kind_e;

    // dispatched opcodes
    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_MUL    = 3'd2,
        OP_BRANCH = 3'd3,
        OP_LOAD   = 3'd4,
        OP_STORE  = 3'd5
    } op_e;

    // execute latencies loaded at reset
    localparam logic [LAT_W-1:0] LAT_INT_DEFAULT    = 4'd1;
    localparam logic [LAT_W-1:0] LAT_MUL_DEFAULT    = 4'd8;   // both multipliers
    localparam logic [LAT_W-1:0] LAT_BRANCH_DEFAULT = 4'd1;
    localparam logic [LAT_W-1:0] LAT_LDST_DEFAULT   = 4'd4;

endpackage

/* source/rs_bank.sv */
`timescale 1ns/1ps

module rs_bank import issue_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dispatch_valid,
    input  op_e                          dispatch_op,
    input  logic [TAG_W-1:0]             dispatch_tag,
    input  logic                         select_flag,
    input  fu_kind_e                     select_signal,
    output logic [NUM_FU-1:0]            instr_ready,
    output logic [NUM_FU-1:0][TAG_W-1:0] rs_tag,
    output logic                         dispatch_reject
);

    logic [NUM_FU-1:0] rs_valid;
    logic [NUM_FU-1:0] issue_clear;   // station emptied at this edge
    logic [NUM_FU-1:0] rs_free;       // free for a dispatch at this edge
    logic [NUM_FU-1:0] fill;          // station chosen for the incoming op

    // the issue unit announced a pick last cycle, that entry leaves now
    always_comb begin
        issue_clear = '0;
        if (select_flag) begin
            issue_clear[select_signal] = 1'b1;
        end
    end

    // a leaving entry frees its slot for a dispatch at the same edge
    assign rs_free = ~rs_valid | issue_clear;

    // steer the opcode to a station, fill stays zero when no slot is free
    always_comb begin
        fill = '0;
        case (dispatch_op)
            OP_ADD, OP_SUB: fill[FU_INT] = rs_free[FU_INT];
            OP_BRANCH:      fill[FU_BRANCH] = rs_free[FU_BRANCH];
            OP_LOAD, OP_STORE: begin
                fill[FU_LDST] = rs_free[FU_LDST];
            end
            OP_MUL: begin
                // mul1 preferred, mul2 only as overflow
                if (rs_free[FU_MUL1]) begin
                    fill[FU_MUL1] = 1'b1;
                end else begin
                    fill[FU_MUL2] = rs_free[FU_MUL2];
                end
            end
            default: fill = '0;   // unknown opcode gets rejected
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rs_valid        <= '0;
            dispatch_reject <= 1'b0;
        end else begin
            rs_valid        <= (rs_valid & ~issue_clear) | ({NUM_FU{dispatch_valid}} & fill);
            dispatch_reject <= dispatch_valid && (fill == '0);   // op is dropped
        end
    end

    // tag storage per station
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_FU; i++) begin
            if (dispatch_valid && fill[i]) begin
                rs_tag[i] <= dispatch_tag;
            end
        end
    end

    assign instr_ready = rs_valid;

endmodule

/* source/fu_latency_regs.sv */
`timescale 1ns/1ps

module fu_latency_regs import issue_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cfg_write,
    input  fu_kind_e                     cfg_unit,
    input  logic [LAT_W-1:0]             cfg_latency,
    output logic [NUM_FU-1:0][LAT_W-1:0] fu_latency
);

    logic cfg_hit;

    // zero latency would never finish, so such a write is dropped
    // out of range unit numbers are dropped too
    assign cfg_hit = cfg_write
                  && (cfg_latency != '0)
                  && (cfg_unit < NUM_FU);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fu_latency[FU_INT]    <= LAT_INT_DEFAULT;
            fu_latency[FU_MUL1]   <= LAT_MUL_DEFAULT;
            fu_latency[FU_MUL2]   <= LAT_MUL_DEFAULT;
            fu_latency[FU_BRANCH] <= LAT_BRANCH_DEFAULT;
            fu_latency[FU_LDST]   <= LAT_LDST_DEFAULT;
        end else if (cfg_hit) begin
            fu_latency[cfg_unit] <= cfg_latency;   // seen by issues from next edge
        end
    end

endmodule

/* source/issue_unit.sv */
`timescale 1ns/1ps

module issue_unit import issue_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [NUM_FU-1:0]            instr_ready,
    input  logic [NUM_FU-1:0][LAT_W-1:0] fu_latency,
    input  logic [NUM_FU-1:0]            fu_hold,
    output logic                         select_flag,
    output fu_kind_e                     select_signal,
    output logic [NUM_FU-1:0]            fu_done
);

    logic [NUM_FU-1:0]            fu_busy;
    logic [NUM_FU-1:0][LAT_W-1:0] fu_count;   // cycles left in execute
    logic [NUM_FU-1:0]            eligible;
    logic [FU_IDX_W-1:0]          rr_ptr;     // highest priority unit this cycle
    logic                         pick_valid;
    logic [FU_IDX_W-1:0]          pick_idx;
    logic [FU_IDX_W-1:0]          next_ptr;

    // held units still wait for their writeback slot
    assign eligible = instr_ready & ~fu_busy & ~fu_hold;

    // rotating search, first eligible unit at or after rr_ptr
    // walking backwards leaves the closest hit as the final assignment
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int off = NUM_FU - 1; off >= 0; off--) begin
            if (eligible[(int'(rr_ptr) + off) % NUM_FU]) begin
                pick_valid = 1'b1;
                pick_idx   = FU_IDX_W'((int'(rr_ptr) + off) % NUM_FU);
            end
        end
    end

    // pointer moves just past the winner
    assign next_ptr = (pick_idx == FU_IDX_W'(NUM_FU - 1)) ? '0 : pick_idx + 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fu_busy       <= '0;
            fu_count      <= '0;
            fu_done       <= '0;
            rr_ptr        <= '0;
            select_flag   <= 1'b0;
            select_signal <= FU_INT;
        end else begin
            fu_done     <= '0;
            select_flag <= pick_valid;

            // countdowns of units in execute
            for (int i = 0; i < NUM_FU; i++) begin
                if (fu_busy[i]) begin
                    fu_count[i] <= fu_count[i] - 1'b1;
                    if (fu_count[i] == LAT_W'(1)) begin
                        fu_busy[i] <= 1'b0;
                        fu_done[i] <= 1'b1;   // one cycle pulse
                    end
                end
            end

            // a picked unit is never busy, so no clash with the loop above
            if (pick_valid) begin
                select_signal      <= fu_kind_e'(pick_idx);
                fu_busy[pick_idx]  <= 1'b1;
                fu_count[pick_idx] <= fu_latency[pick_idx];
                rr_ptr             <= next_ptr;
            end
        end
    end

endmodule

/* source/writeback_arbiter.sv */
`timescale 1ns/1ps

module writeback_arbiter import issue_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         select_flag,
    input  fu_kind_e                     select_signal,
    input  logic [NUM_FU-1:0][TAG_W-1:0] rs_tag,
    input  logic [NUM_FU-1:0]            fu_done,
    output logic [NUM_FU-1:0]            fu_hold,
    output logic                         complete_valid,
    output logic [TAG_W-1:0]             complete_tag
);

    logic [NUM_FU-1:0][TAG_W-1:0] exec_tag;   // tag of the op in each unit
    logic [NUM_FU-1:0]            pending;
    logic [NUM_FU-1:0]            wb_req;
    logic [NUM_FU-1:0]            wb_grant;
    logic [FU_IDX_W-1:0]          grant_idx;

    // a done pulse is already a request in its own cycle
    assign wb_req = pending | fu_done;

    // unit stays blocked until its tag has gone out,
    // otherwise a reissue would overwrite exec_tag too early
    assign fu_hold = wb_req;

    // lowest index wins
    assign wb_grant = wb_req & (~wb_req + 1'b1);

    always_comb begin
        grant_idx = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            if (wb_req[i]) begin
                grant_idx = FU_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending        <= '0;
            complete_valid <= 1'b0;
        end else begin
            pending        <= wb_req & ~wb_grant;   // losers wait a cycle
            complete_valid <= |wb_req;
        end
    end

    // station entry is still valid on the edge that sees select_flag
    always_ff @(posedge clk) begin
        if (select_flag) begin
            exec_tag[select_signal] <= rs_tag[select_signal];
        end
        if (|wb_req) begin
            complete_tag <= exec_tag[grant_idx];
        end
    end

endmodule

/* source/issue_core.sv */
`timescale 1ns/1ps

module issue_core import issue_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    // dispatch port
    input  logic             dispatch_valid,
    input  op_e              dispatch_op,
    input  logic [TAG_W-1:0] dispatch_tag,
    output logic             dispatch_reject,
    // latency configuration
    input  logic             cfg_write,
    input  fu_kind_e         cfg_unit,
    input  logic [LAT_W-1:0] cfg_latency,
    // issue and completion
    output logic             select_flag,
    output fu_kind_e         select_signal,
    output logic             complete_valid,
    output logic [TAG_W-1:0] complete_tag
);

    logic [NUM_FU-1:0]            instr_ready;
    logic [NUM_FU-1:0][TAG_W-1:0] rs_tag;
    logic [NUM_FU-1:0][LAT_W-1:0] fu_latency;
    logic [NUM_FU-1:0]            fu_done;
    logic [NUM_FU-1:0]            fu_hold;   // completion pending per unit

    rs_bank u_rs_bank (
        .clk             (clk),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_op     (dispatch_op),
        .dispatch_tag    (dispatch_tag),
        .select_flag     (select_flag),
        .select_signal   (select_signal),
        .instr_ready     (instr_ready),
        .rs_tag          (rs_tag),
        .dispatch_reject (dispatch_reject)
    );

    fu_latency_regs u_fu_latency_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_write   (cfg_write),
        .cfg_unit    (cfg_unit),
        .cfg_latency (cfg_latency),
        .fu_latency  (fu_latency)
    );

    issue_unit u_issue_unit (
        .clk           (clk),
        .reset         (reset),
        .instr_ready   (instr_ready),
        .fu_latency    (fu_latency),
        .fu_hold       (fu_hold),
        .select_flag   (select_flag),
        .select_signal (select_signal),
        .fu_done       (fu_done)
    );

    writeback_arbiter u_writeback_arbiter (
        .clk            (clk),
        .reset          (reset),
        .select_flag    (select_flag),
        .select_signal  (select_signal),
        .rs_tag         (rs_tag),
        .fu_done        (fu_done),
        .fu_hold        (fu_hold),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag)
    );

endmodule

/* bench/issue_core_tb.sv */
`timescale 1ns/1ps

module issue_core_tb import issue_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 400;   // rough sum of all test lengths
    localparam int MARGIN      = 100;

    logic             clk;
    logic             reset;
    logic             dispatch_valid;
    op_e              dispatch_op;
    logic [TAG_W-1:0] dispatch_tag;
    logic             dispatch_reject;
    logic             cfg_write;
    fu_kind_e         cfg_unit;
    logic [LAT_W-1:0] cfg_latency;
    logic             select_flag;
    fu_kind_e         select_signal;
    logic             complete_valid;
    logic [TAG_W-1:0] complete_tag;

    integer           seed = 46054;
    int               cycle = 0;
    int               mismatch_count = 0;
    int               other_count = 0;
    logic [15:0]      tags_used;   // tags handed out in the current test

    // what the monitor saw since the last clear
    fu_kind_e         sel_units[$];
    int               sel_cycles[$];
    logic [TAG_W-1:0] cmp_tags[$];
    int               cmp_cycles[$];

    issue_core dut (
        .clk             (clk),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_op     (dispatch_op),
        .dispatch_tag    (dispatch_tag),
        .dispatch_reject (dispatch_reject),
        .cfg_write       (cfg_write),
        .cfg_unit        (cfg_unit),
        .cfg_latency     (cfg_latency),
        .select_flag     (select_flag),
        .select_signal   (select_signal),
        .complete_valid  (complete_valid),
        .complete_tag    (complete_tag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && select_flag) begin
            sel_units.push_back(select_signal);
            sel_cycles.push_back(cycle);
        end
        if (!reset && complete_valid) begin
            cmp_tags.push_back(complete_tag);
            cmp_cycles.push_back(cycle);
        end
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", TEST_CYCLES + MARGIN);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_unit(input string name, input fu_kind_e got, input fu_kind_e exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatch_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic clear_records();
        sel_units.delete();
        sel_cycles.delete();
        cmp_tags.delete();
        cmp_cycles.delete();
        tags_used = '0;
    endtask

    // distinct tags inside one test so the order on the bus is visible
    function automatic logic [TAG_W-1:0] draw_tag();
        logic [TAG_W-1:0] t;
        t = TAG_W'($random(seed));
        while (tags_used[t]) begin
            t = TAG_W'($random(seed));
        end
        tags_used[t] = 1'b1;
        return t;
    endfunction

    function automatic op_e op_for_unit(input fu_kind_e unit);
        case (unit)
            FU_INT:    return OP_ADD;
            FU_BRANCH: return OP_BRANCH;
            FU_LDST:   return OP_LOAD;
            default:   return OP_MUL;   // either multiplier
        endcase
    endfunction

    task automatic dispatch(input op_e op, input logic [TAG_W-1:0] tag, input logic exp_reject);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_tag   = tag;
        next_cycle();
        dispatch_valid = 1'b0;
        check_bit("dispatch_reject", dispatch_reject, exp_reject);
    endtask

    task automatic write_latency(input fu_kind_e unit, input logic [LAT_W-1:0] lat);
        cfg_write   = 1'b1;
        cfg_unit    = unit;
        cfg_latency = lat;
        next_cycle();
        cfg_write   = 1'b0;
    endtask

    task automatic wait_completions(input int count, input int limit);
        int waited;
        waited = 0;
        while (cmp_tags.size() < count && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (cmp_tags.size() < count) begin
            other_count++;
            $display("only %0d of %0d completions arrived within %0d cycles",
                     cmp_tags.size(), count, limit);
        end
    endtask

    // one op alone, lat is the latency the unit should run with
    task automatic run_single(input op_e op, input fu_kind_e exp_unit, input int lat);
        logic [TAG_W-1:0] tag;
        clear_records();
        tag = draw_tag();
        dispatch(op, tag, 1'b0);
        wait_completions(1, 40);
        check_count("select count", sel_units.size(), 1);
        if (sel_units.size() == 1 && cmp_tags.size() == 1) begin
            check_unit("select_signal", sel_units[0], exp_unit);
            check_tag("complete_tag", cmp_tags[0], tag);
            check_count("select to complete cycles", cmp_cycles[0] - sel_cycles[0], lat + 1);
        end
    endtask

    task automatic test_single_class();
        run_single(OP_ADD, FU_INT, LAT_INT_DEFAULT);
        run_single(OP_MUL, FU_MUL1, LAT_MUL_DEFAULT);
        run_single(OP_BRANCH, FU_BRANCH, LAT_BRANCH_DEFAULT);
        run_single(OP_LOAD, FU_LDST, LAT_LDST_DEFAULT);
    endtask

    task automatic test_latency_config();
        write_latency(FU_LDST, 4'd3);
        run_single(OP_STORE, FU_LDST, 3);
        write_latency(FU_LDST, 4'd0);   // ignored, still 3
        run_single(OP_LOAD, FU_LDST, 3);
    endtask

    task automatic test_mul_steering();
        logic [TAG_W-1:0] tags [5];
        clear_records();
        foreach (tags[i]) tags[i] = draw_tag();
        // occupy both multipliers first
        dispatch(OP_MUL, tags[0], 1'b0);
        dispatch(OP_MUL, tags[1], 1'b0);
        wait_cycles(2);
        // stations wait behind busy units now
        dispatch(OP_MUL, tags[2], 1'b0);
        dispatch(OP_MUL, tags[3], 1'b0);
        dispatch(OP_MUL, tags[4], 1'b1);
        wait_completions(4, 60);
        wait_cycles(20);   // a dropped tag would show up by now
        check_count("completion count", cmp_tags.size(), 4);
        if (cmp_tags.size() == 4 && sel_units.size() == 4) begin
            for (int i = 0; i < 4; i++) begin
                check_unit("select_signal", sel_units[i], (i % 2 == 0) ? FU_MUL1 : FU_MUL2);
                check_tag("complete_tag", cmp_tags[i], tags[i]);
            end
        end
    endtask

    task automatic test_add_reject();
        logic [TAG_W-1:0] first_tag;
        logic [TAG_W-1:0] second_tag;
        clear_records();
        first_tag  = draw_tag();
        second_tag = draw_tag();
        dispatch(OP_ADD, first_tag, 1'b0);
        dispatch(OP_ADD, second_tag, 1'b1);   // int station not yet cleared
        wait_completions(1, 20);
        wait_cycles(5);
        check_count("completion count", cmp_tags.size(), 1);
        if (cmp_tags.size() == 1) begin
            check_tag("complete_tag", cmp_tags[0], first_tag);
        end
    endtask

    task automatic test_rotation();
        op_e refill[$];
        int  sent;
        int  cyc;
        clear_records();
        for (int u = 0; u < NUM_FU; u++) begin
            write_latency(fu_kind_e'(u), 4'd1);
        end
        refill = '{OP_ADD, OP_MUL, OP_MUL, OP_BRANCH, OP_LOAD};
        sent = 0;
        cyc  = 0;
        while ((cyc < 25 || refill.size() > 0) && cyc < 60) begin
            if (select_flag && cyc < 25) begin
                refill.push_back(op_for_unit(select_signal));   // station just issued
            end
            if (refill.size() > 0) begin
                dispatch_valid = 1'b1;
                dispatch_op    = refill.pop_front();
                dispatch_tag   = TAG_W'($random(seed));
                sent++;
            end else begin
                dispatch_valid = 1'b0;
            end
            next_cycle();
            check_bit("dispatch_reject", dispatch_reject, 1'b0);
            cyc++;
        end
        dispatch_valid = 1'b0;
        wait_completions(sent, 40);
        check_count("select count", sel_units.size(), sent);
        // every unit eligible in turn, so the pointer walks 0..4
        for (int i = 0; i < sel_units.size(); i++) begin
            check_unit("select_signal", sel_units[i], fu_kind_e'(i % NUM_FU));
        end
    endtask

    task automatic test_wb_contention();
        logic [TAG_W-1:0] tags [4];
        clear_records();
        foreach (tags[i]) tags[i] = draw_tag();
        write_latency(FU_MUL1, 4'd5);
        write_latency(FU_MUL2, 4'd5);
        write_latency(FU_LDST, 4'd4);   // issues one cycle after mul2, same finish
        dispatch(OP_MUL, tags[0], 1'b0);
        dispatch(OP_MUL, tags[1], 1'b0);
        dispatch(OP_LOAD, tags[2], 1'b0);
        wait_cycles(1);
        dispatch(OP_LOAD, tags[3], 1'b0);
        wait_completions(4, 40);
        if (cmp_tags.size() == 4 && sel_units.size() == 4) begin
            for (int i = 0; i < 4; i++) begin
                check_tag("complete_tag", cmp_tags[i], tags[i]);
            end
            check_count("mul2 to ldst writeback gap", cmp_cycles[2] - cmp_cycles[1], 1);
            check_unit("select_signal", sel_units[3], FU_LDST);
            if (sel_cycles[3] <= cmp_cycles[2]) begin
                other_count++;
                $display("load/store unit reissued before its earlier tag was written back");
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_tag   = '0;
        cfg_write      = 1'b0;
        cfg_unit       = FU_INT;
        cfg_latency    = '0;
        tags_used      = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_bit("select_flag", select_flag, 1'b0);
        check_bit("complete_valid", complete_valid, 1'b0);
        check_bit("dispatch_reject", dispatch_reject, 1'b0);

        test_single_class();
        test_latency_config();
        test_mul_steering();
        test_add_reject();
        test_rotation();
        test_wb_contention();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* build.f */
source/issue_pkg.sv
source/rs_bank.sv
source/fu_latency_regs.sv
source/issue_unit.sv
source/writeback_arbiter.sv
source/issue_core.sv
bench/issue_core_tb.sv
